// ==== include/riscv_defines.svh ====
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

`define XLEN          32       // Data and instruction width
`define IMEM_WORDS    64       // Instruction RAM depth
`define DMEM_WORDS    64       // Data RAM depth
`define WORD_IDX_W    6        // Word index width of both RAMs

// APB address map, 256-byte regions
`define APB_AW        12
`define APB_IMEM_BASE 12'h000
`define APB_DMEM_BASE 12'h100
`define APB_REGS_BASE 12'h200  // x0..x31 at 0x200..0x27C
`define APB_STEP_ADDR 12'h300  // Step budget register

`endif

// ==== design/RiscvPkg.sv ====
`include "riscv_defines.svh"

package RiscvPkg;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,  // ADD SUB AND OR XOR
        OP_IMM    = 7'b0010011,  // ADDI ANDI ORI XORI
        OP_LOAD   = 7'b0000011,  // LW
        OP_STORE  = 7'b0100011,  // SW
        OP_BRANCH = 7'b1100011,  // BEQ BNE
        OP_JAL    = 7'b1101111
    } Opcode;

    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SUB = 4'b0001,       // Also used for branch compare
        ALU_AND = 4'b0010,
        ALU_OR  = 4'b0011,
        ALU_XOR = 4'b0100
    } AluOp;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J
    } ImmSel;

    typedef struct packed {
        logic  regWrite;         // Write rd at retire
        AluOp  aluCtl;
        logic  aluSrc;           // 1 = immediate operand
        ImmSel immSrc;
        logic  memWrite;         // Store
        logic  memToReg;         // Load result to rd
        logic  branchEq;
        logic  branchNe;
        logic  jump;             // PC = PC + imm
        logic  linkPc;           // rd = PC + 4
    } CtrlWord;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [`APB_AW-1:0] paddr;
        logic [`XLEN-1:0]  pwdata;
    } ApbReq;

    typedef struct packed {
        logic                  en;
        logic [`WORD_IDX_W-1:0] addr;  // Word index
        logic [`XLEN-1:0]      data;
    } MemWrite;

endpackage

// ==== design/ApbHostPort.sv ====
`include "riscv_defines.svh"

module ApbHostPort (
    input  logic                   clk,
    input  logic                   rst,
    input  RiscvPkg::ApbReq        req,           // Host bus request
    output logic [`XLEN-1:0]       prdata,
    output logic                   pready,
    output logic                   pslverr,
    output RiscvPkg::MemWrite      imemWr,        // Program load strobe
    output RiscvPkg::MemWrite      dmemHostWr,
    output logic [`WORD_IDX_W-1:0] dmemHostAddr,  // Host read index
    input  logic [`XLEN-1:0]       dmemHostData,
    output logic [4:0]             regIdx,        // Register readback select
    input  logic [`XLEN-1:0]       regData,
    output logic                   stepEn,        // Budget nonzero
    input  logic                   stepDone       // Retire pulse from the core
);
    localparam logic [`APB_AW-1:0] REGION_MASK = {{(`APB_AW - 8){1'b1}}, 8'h00};

    logic                 access;
    logic                 wrAccess;
    logic [`APB_AW-1:0]   region;
    logic                 isImem;
    logic                 isDmem;
    logic                 isRegs;
    logic                 isStep;
    logic                 inMap;
    logic [`XLEN-1:0]     stepBudget;  // Instructions left to retire

    assign access   = req.psel & req.penable;    // Access phase
    assign wrAccess = access & req.pwrite;
    assign region   = req.paddr & REGION_MASK;

    assign isImem = (region == `APB_IMEM_BASE);
    assign isDmem = (region == `APB_DMEM_BASE);
    assign isRegs = (region == `APB_REGS_BASE) && !req.paddr[7];  // Only 32 words
    assign isStep = (req.paddr == `APB_STEP_ADDR);
    assign inMap  = isImem | isDmem | isRegs | isStep;

    assign pready  = access;                     // No wait states
    assign pslverr = access & (~inMap | (req.pwrite & isRegs));

    // Byte address to word index in each region
    assign dmemHostAddr = req.paddr[`WORD_IDX_W+1:2];
    assign regIdx       = req.paddr[6:2];

    always_comb begin
        imemWr.en       = wrAccess & isImem;
        imemWr.addr     = req.paddr[`WORD_IDX_W+1:2];
        imemWr.data     = req.pwdata;
        dmemHostWr.en   = wrAccess & isDmem;
        dmemHostWr.addr = req.paddr[`WORD_IDX_W+1:2];
        dmemHostWr.data = req.pwdata;
    end

    always_comb begin
        prdata = '0;                             // Idle bus and imem reads give zero
        if (access && !req.pwrite) begin
            if (isDmem) begin
                prdata = dmemHostData;
            end else if (isRegs) begin
                prdata = regData;
            end else if (isStep) begin
                prdata = stepBudget;             // Host polls this to zero
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stepBudget <= '0;
        end else if (wrAccess && isStep) begin
            stepBudget <= req.pwdata;            // Host write wins over retire
        end else if (stepDone) begin
            stepBudget <= stepBudget - 1'b1;
        end
    end

    assign stepEn = (stepBudget != '0);

endmodule

// ==== design/InstrMemory.sv ====
`include "riscv_defines.svh"

module InstrMemory (
    input  logic                   clk,
    input  RiscvPkg::MemWrite      wr,     // Host program load
    input  logic [`WORD_IDX_W-1:0] pcIdx,  // Fetch word index, wraps with depth
    output logic [`XLEN-1:0]       instr
);
    logic [`XLEN-1:0] mem [`IMEM_WORDS];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    assign instr = mem[pcIdx];  // Combinational fetch

endmodule

// ==== design/ControlUnit.sv ====
`include "riscv_defines.svh"

module ControlUnit (
    input  logic [`XLEN-1:0] instr,
    output RiscvPkg::CtrlWord ctrl   // Decoded control for the datapath
);
    import RiscvPkg::*;

    Opcode      opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = Opcode'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        ctrl = '0;                               // Unknown opcode retires as a no-op
        case (opcode)
            OP_R: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluCtl = (funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
                    3'b111:  ctrl.aluCtl = ALU_AND;
                    3'b110:  ctrl.aluCtl = ALU_OR;
                    3'b100:  ctrl.aluCtl = ALU_XOR;
                    default: ctrl.aluCtl = ALU_ADD;
                endcase
            end
            OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = IMM_I;
                case (funct3)
                    3'b000:  ctrl.aluCtl = ALU_ADD;
                    3'b111:  ctrl.aluCtl = ALU_AND;
                    3'b110:  ctrl.aluCtl = ALU_OR;
                    3'b100:  ctrl.aluCtl = ALU_XOR;
                    default: ctrl.aluCtl = ALU_ADD;
                endcase
            end
            OP_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = IMM_I;
                ctrl.aluCtl   = ALU_ADD;         // Address = rs1 + imm
                ctrl.memToReg = 1'b1;
            end
            OP_STORE: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = IMM_S;
                ctrl.aluCtl   = ALU_ADD;
                ctrl.memWrite = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.immSrc = IMM_B;
                ctrl.aluCtl = ALU_SUB;           // Compare via difference
                case (funct3)
                    3'b000:  ctrl.branchEq = 1'b1;
                    3'b001:  ctrl.branchNe = 1'b1;
                    default: ctrl.branchEq = 1'b0;  // Other compares never taken
                endcase
            end
            OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.immSrc   = IMM_J;
                ctrl.jump     = 1'b1;
                ctrl.linkPc   = 1'b1;            // rd gets return address
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== design/Datapath.sv ====
`include "riscv_defines.svh"

module Datapath (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stepEn,     // Retire one instruction this cycle
    output logic [`WORD_IDX_W-1:0] pcIdx,
    input  logic [`XLEN-1:0]       instr,
    output logic [`XLEN-1:0]       ctrlInstr,  // To the decoder
    input  RiscvPkg::CtrlWord      ctrl,
    output logic [`XLEN-1:0]       dAddr,
    output logic [`XLEN-1:0]       dWdata,
    output logic                   dWe,
    input  logic [`XLEN-1:0]       dRdata,
    input  logic [4:0]             regIdx,     // Host readback select
    output logic [`XLEN-1:0]       regData,
    output logic                   stepDone
);
    import RiscvPkg::*;

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] nextPc;
    logic [`XLEN-1:0] regFile [32];
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic [`XLEN-1:0] rs1Val;
    logic [`XLEN-1:0] rs2Val;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] wbData;
    logic             branchTaken;

    assign ctrlInstr = instr;
    assign pcIdx     = pc[`WORD_IDX_W+1:2];  // Fetch ignores pc[1:0]
    assign pcPlus4   = pc + 32'd4;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // x0 reads as zero, never stored
    assign rs1Val  = (rs1 == 5'd0) ? '0 : regFile[rs1];
    assign rs2Val  = (rs2 == 5'd0) ? '0 : regFile[rs2];
    assign regData = (regIdx == 5'd0) ? '0 : regFile[regIdx];

    always_comb begin
        case (ctrl.immSrc)
            IMM_I:   imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    assign aluB = ctrl.aluSrc ? imm : rs2Val;

    always_comb begin
        case (ctrl.aluCtl)
            ALU_ADD: aluResult = rs1Val + aluB;
            ALU_SUB: aluResult = rs1Val - aluB;
            ALU_AND: aluResult = rs1Val & aluB;
            ALU_OR:  aluResult = rs1Val | aluB;
            ALU_XOR: aluResult = rs1Val ^ aluB;
            default: aluResult = rs1Val + aluB;
        endcase
    end

    // Branch on zero or nonzero difference
    assign branchTaken = (ctrl.branchEq & (aluResult == '0))
                       | (ctrl.branchNe & (aluResult != '0));
    assign nextPc = (branchTaken | ctrl.jump) ? pc + imm : pcPlus4;

    // Data port, low address bits dropped in the RAM
    assign dAddr  = aluResult;
    assign dWdata = rs2Val;
    assign dWe    = stepEn & ctrl.memWrite;

    always_comb begin
        if (ctrl.linkPc) begin
            wbData = pcPlus4;                     // JAL return address
        end else if (ctrl.memToReg) begin
            wbData = dRdata;
        end else begin
            wbData = aluResult;
        end
    end

    always_ff @(posedge clk) begin
        if (stepEn && ctrl.regWrite && rd != 5'd0) begin
            regFile[rd] <= wbData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (stepEn) begin
            pc <= nextPc;                         // Same edge as rd and store
        end
    end

    assign stepDone = stepEn;                     // Single cycle retire

endmodule

// ==== design/DataMemory.sv ====
`include "riscv_defines.svh"

module DataMemory (
    input  logic                   clk,
    input  logic                   dWe,       // Core store
    input  logic [`XLEN-1:0]       dAddr,     // Byte address from the ALU
    input  logic [`XLEN-1:0]       dWdata,
    output logic [`XLEN-1:0]       dRdata,
    input  RiscvPkg::MemWrite      hostWr,
    input  logic [`WORD_IDX_W-1:0] hostAddr,  // Host read index
    output logic [`XLEN-1:0]       hostData
);
    logic [`XLEN-1:0]       mem [`DMEM_WORDS];
    logic [`WORD_IDX_W-1:0] coreIdx;

    assign coreIdx = dAddr[`WORD_IDX_W+1:2];  // Word aligned, wraps with depth

    always_ff @(posedge clk) begin
        if (hostWr.en) begin
            mem[hostWr.addr] <= hostWr.data;
        end
        if (dWe) begin
            mem[coreIdx] <= dWdata;             // Later write, core wins on collision
        end
    end

    assign dRdata   = mem[coreIdx];
    assign hostData = mem[hostAddr];

endmodule

// ==== design/RiscvTop.sv ====
`include "riscv_defines.svh"

module RiscvTop (
    input  logic               clk,
    input  logic               rst,
    input  RiscvPkg::ApbReq    apbReq,
    output logic [`XLEN-1:0]   prdata,
    output logic               pready,
    output logic               pslverr
);
    import RiscvPkg::*;

    MemWrite                imemWr;        // Host program load
    MemWrite                dmemHostWr;
    logic [`WORD_IDX_W-1:0] dmemHostAddr;
    logic [`XLEN-1:0]       dmemHostData;
    logic [4:0]             regIdx;
    logic [`XLEN-1:0]       regData;
    logic                   stepEn;
    logic                   stepDone;
    logic [`WORD_IDX_W-1:0] pcIdx;
    logic [`XLEN-1:0]       instr;
    logic [`XLEN-1:0]       ctrlInstr;
    CtrlWord                ctrl;
    logic [`XLEN-1:0]       dAddr;
    logic [`XLEN-1:0]       dWdata;
    logic                   dWe;
    logic [`XLEN-1:0]       dRdata;

    ApbHostPort hostPort (
        .clk(clk), .rst(rst), .req(apbReq),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .imemWr(imemWr), .dmemHostWr(dmemHostWr),
        .dmemHostAddr(dmemHostAddr), .dmemHostData(dmemHostData),
        .regIdx(regIdx), .regData(regData),
        .stepEn(stepEn), .stepDone(stepDone)
    );

    InstrMemory imem (
        .clk(clk), .wr(imemWr), .pcIdx(pcIdx), .instr(instr)
    );

    ControlUnit ctrlUnit (
        .instr(ctrlInstr), .ctrl(ctrl)
    );

    Datapath datapath (
        .clk(clk), .rst(rst), .stepEn(stepEn),
        .pcIdx(pcIdx), .instr(instr),
        .ctrlInstr(ctrlInstr), .ctrl(ctrl),
        .dAddr(dAddr), .dWdata(dWdata), .dWe(dWe), .dRdata(dRdata),
        .regIdx(regIdx), .regData(regData),
        .stepDone(stepDone)
    );

    DataMemory dmem (
        .clk(clk), .dWe(dWe), .dAddr(dAddr), .dWdata(dWdata), .dRdata(dRdata),
        .hostWr(dmemHostWr), .hostAddr(dmemHostAddr), .hostData(dmemHostData)
    );

endmodule

// ==== sim/RiscvTop_properties.sv ====
`include "riscv_defines.svh"

module RiscvTopProperties (
    input logic             clk,
    input logic             rst,
    input RiscvPkg::ApbReq  apbReq,
    input logic             pready,
    input logic             stepEn,
    input logic [`XLEN-1:0] stepBudget,  // Budget register inside the port
    input logic [`XLEN-1:0] pc
);
    logic stepWr;
    int   failCount = 0;                 // Failed checks so far

    assign stepWr = apbReq.psel & apbReq.penable & apbReq.pwrite
                  & (apbReq.paddr == `APB_STEP_ADDR);  // Host reloads the budget

    readyInAccess: assert property (@(posedge clk) disable iff (rst)
        pready == (apbReq.psel & apbReq.penable))
        else begin
            failCount++;
            $error("PREADY does not follow the APB access phase");
        end

    budgetNoWrap: assert property (@(posedge clk) disable iff (rst)
        (stepBudget == '0 && !stepWr) |=> stepBudget == '0)
        else begin
            failCount++;
            $error("Step budget went below zero");
        end

    // Idle core keeps its PC
    pcHoldsIdle: assert property (@(posedge clk) disable iff (rst)
        !stepEn |=> $stable(pc))
        else begin
            failCount++;
            $error("PC changed while no step was enabled");
        end

endmodule

bind RiscvTop RiscvTopProperties props0 (
    .clk(clk), .rst(rst), .apbReq(apbReq), .pready(pready), .stepEn(stepEn),
    .stepBudget(hostPort.stepBudget), .pc(datapath.pc)
);

// ==== sim/RiscvTb.sv ====
`include "riscv_defines.svh"

module RiscvTb;
    import RiscvPkg::*;

    localparam int APB_XFERS = 512;                 // Bound on host transfers

    logic             clk = 1'b0;
    logic             rst;
    ApbReq            apbReq;
    logic [`XLEN-1:0] prdata;
    logic             pready;
    logic             pslverr;

    integer      seed = 32'h5dae_ec1c;
    int          totalBudget = 0;
    logic [31:0] prog [`IMEM_WORDS];                // Program image the model also runs
    logic [31:0] mRegs [32];
    logic [31:0] mMem [`DMEM_WORDS];
    logic [31:0] mPc;
    logic [2:0]  aluF3 [4] = '{3'b000, 3'b100, 3'b110, 3'b111};  // ADD XOR OR AND

    RiscvTop dut0 (
        .clk(clk), .rst(rst), .apbReq(apbReq),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #4 clk = ~clk;                           // 8 unit period

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Stopped at the first error");
    endtask

    function automatic int unsigned urand(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Setup, access, then idle so a write lands exactly once
    task automatic apbXfer(input logic wr, input logic [`APB_AW-1:0] addr,
                           input logic [31:0] wdata, input logic expErr,
                           output logic [31:0] rdata);
        @(posedge clk);
        apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apbReq.penable <= 1'b1;
        @(negedge clk);                             // Mid access cycle
        rdata = prdata;
        assert (pready) else failNow("PREADY stayed low in an access cycle");
        assert (pslverr == expErr) else failNow($sformatf(
            "Mismatch at %0t: PSLVERR %b at address %h", $time, pslverr, addr));
        @(posedge clk);
        apbReq <= '0;
    endtask

    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b);
        case (f3)
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    function automatic logic [31:0] genInstr(input int idx);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [12:0] bOff;
        logic [20:0] jOff;
        r    = $random(seed);
        f3   = aluF3[urand(4)];
        f7   = (f3 == 3'b000 && r[31]) ? 7'b0100000 : 7'b0000000;  // SUB half the time
        bOff = {{6{r[29]}}, r[29:25], 2'b00};       // Word aligned within +-64 bytes
        jOff = {{14{r[29]}}, r[29:25], 2'b00};
        if (idx < 31) begin
            return {r[11:0], 5'd0, 3'b000, 5'(idx + 1), 7'b0010011};  // ADDI seeds x1..x31
        end
        case (urand(16))
            0, 1, 2, 3: return {f7, r[24:20], r[19:15], f3, r[11:7], 7'b0110011};
            4, 5, 6:    return {r[31:20], r[19:15], f3, r[11:7], 7'b0010011};
            7, 8:       return {r[31:20], 5'd0, 3'b010, r[11:7], 7'b0000011};   // LW off x0
            9, 10:      return {r[31:25], r[24:20], 5'd0, 3'b010, r[11:7], 7'b0100011};
            11, 12:     return {bOff[12], bOff[10:5], r[24:20], r[19:15], 2'b00, r[0],
                                bOff[4:1], bOff[11], 7'b1100011};
            13:         return {bOff[12], bOff[10:5], r[24:20], r[19:15], 3'(2 + urand(6)),
                                bOff[4:1], bOff[11], 7'b1100011};  // Funct3 never taken
            14:         return {jOff[20], jOff[10:1], jOff[11], jOff[19:12], r[11:7],
                                7'b1101111};
            default:    return {r[31:7], 7'b0001011};  // Custom opcode
        endcase
    endfunction

    task automatic modelStep();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] wb;
        logic [31:0] nextPc;
        logic        wbEn;
        ins    = prog[mPc[7:2]];                    // Fetch wraps at 64 words
        a      = mRegs[ins[19:15]];
        b      = mRegs[ins[24:20]];
        wb     = '0;
        wbEn   = 1'b0;
        nextPc = mPc + 32'd4;
        case (ins[6:0])
            7'b0110011: begin
                wbEn = 1'b1;
                wb   = (ins[14:12] == 3'b000 && ins[31:25] == 7'b0100000)
                     ? a - b : aluModel(ins[14:12], a, b);
            end
            7'b0010011: begin
                wbEn = 1'b1;
                wb   = aluModel(ins[14:12], a, {{20{ins[31]}}, ins[31:20]});
            end
            7'b0000011: begin
                addr = a + {{20{ins[31]}}, ins[31:20]};
                wbEn = 1'b1;
                wb   = mMem[addr[7:2]];             // Low bits dropped with wrap
            end
            7'b0100011: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mMem[addr[7:2]] = b;
            end
            7'b1100011: begin
                if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                    nextPc = mPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                wbEn   = 1'b1;
                wb     = mPc + 32'd4;               // Link
                nextPc = mPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ;                              // No-op
        endcase
        if (wbEn && ins[11:7] != 5'd0) begin
            mRegs[ins[11:7]] = wb;
        end
        mPc = nextPc;
    endtask

    task automatic checkState();
        logic [31:0] got;
        for (int i = 0; i < 32; i++) begin
            apbXfer(1'b0, `APB_REGS_BASE + 12'(i * 4), '0, 1'b0, got);
            assert (got === mRegs[i]) else failNow($sformatf(
                "Mismatch at %0t: x%0d is %h, model has %h", $time, i, got, mRegs[i]));
        end
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            apbXfer(1'b0, `APB_DMEM_BASE + 12'(i * 4), '0, 1'b0, got);
            assert (got === mMem[i]) else failNow($sformatf(
                "Mismatch at %0t: dmem[%0d] is %h, model has %h", $time, i, got, mMem[i]));
        end
    endtask

    task automatic runBudget(input int n);
        logic [31:0] left;
        apbXfer(1'b1, `APB_STEP_ADDR, 32'(n), 1'b0, left);
        repeat (n) modelStep();
        do begin
            apbXfer(1'b0, `APB_STEP_ADDR, '0, 1'b0, left);
        end while (left != 0);                      // Poll until the core idles
        checkState();
    endtask

    initial begin
        logic [31:0] val;
        int          budget1;
        int          budget2;
        budget1     = 40 + int'(urand(80));         // Covers the 31 seeding ADDIs
        budget2     = 1 + int'(urand(80));
        totalBudget = budget1 + budget2;
        apbReq      = '0;
        rst         = 1'b1;
        mPc         = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        apbXfer(1'b0, `APB_STEP_ADDR, '0, 1'b0, val);
        assert (val == '0) else failNow($sformatf(
            "Mismatch at %0t: step register %h after reset", $time, val));
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
        end
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            prog[i] = genInstr(i);
            apbXfer(1'b1, `APB_IMEM_BASE + 12'(i * 4), prog[i], 1'b0, val);
        end
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mMem[i] = $random(seed);
            apbXfer(1'b1, `APB_DMEM_BASE + 12'(i * 4), mMem[i], 1'b0, val);
        end
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            apbXfer(1'b0, `APB_DMEM_BASE + 12'(i * 4), '0, 1'b0, val);
            assert (val === mMem[i]) else failNow($sformatf(
                "Mismatch at %0t: dmem[%0d] read %h, wrote %h", $time, i, val, mMem[i]));
        end
        apbXfer(1'b1, `APB_REGS_BASE + 12'h004, 32'h1234, 1'b1, val);  // Registers are read only
        apbXfer(1'b0, 12'h400, '0, 1'b1, val);     // Outside the map
        runBudget(budget1);
        runBudget(budget2);                         // Continues from the same PC
        if (dut0.props0.failCount == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            failNow("A bound assertion on the DUT failed");
        end
    end

    initial begin
        wait (totalBudget != 0);
        #((totalBudget * 64 + APB_XFERS * 3 + 16) * 8);
        $display("Timeout: the run did not finish in the expected time");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        wait (dut0.props0.failCount != 0);          // A bound assertion fired
        failNow("A bound assertion on the DUT failed");
    end

endmodule

// ==== vlog.f ====
+incdir+include
design/RiscvPkg.sv
design/ApbHostPort.sv
design/InstrMemory.sv
design/ControlUnit.sv
design/Datapath.sv
design/DataMemory.sv
design/RiscvTop.sv
sim/RiscvTop_properties.sv
sim/RiscvTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= RiscvTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
